// ==== hdl/dataBusPkg.sv ====
package dataBusPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [15:0] busAddr;   // Byte address.
    typedef logic [31:0] busData;   // Data word.
    typedef logic [3:0]  laneMask;  // One enable per byte lane.
    typedef logic [9:0]  bankAddr;  // Word index inside the RAM.
    typedef logic [3:0]  ioIndex;   // I/O register index.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam busAddr ramBase  = 16'h0000;
    localparam int     ramBytes = 4096;
    localparam busAddr ioBase   = 16'h1000;
    localparam int     ioWords  = 16;    // Window spans four bytes per register.

    typedef enum logic [1:0] {
        accessByte = 2'd0,
        accessHalf = 2'd1,
        accessWord = 2'd2
    } dataAccess;

    typedef enum logic [1:0] {
        regionRam  = 2'd0,
        regionIo   = 2'd1,
        regionNone = 2'd2
    } busRegion;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        busAddr    addr;
        dataAccess access;
        logic      signedLoad;  // Sign-extend byte and half loads.
        logic      wrEnable;
        logic      rdEnable;
        busData    wrData;
    } busRequest;

    typedef struct packed {
        busRegion region;
        laneMask  lanes;     // Already qualified by the write strobe.
        busData   data;      // Store data moved onto its lanes.
        bankAddr  wordAddr;
        ioIndex   ioSel;
    } alignedWrite;

    typedef struct packed {
        busRegion  region;
        dataAccess access;
        logic      signedLoad;
        logic [1:0] byteOffset;
    } loadContext;

endpackage

// ==== hdl/accessDecoder.sv ====
`timescale 1ns/1ps

module accessDecoder (
    input  dataBusPkg::busRequest   req,
    output dataBusPkg::alignedWrite wr,
    output dataBusPkg::loadContext  ctx
);

    logic [31:0]         ramOff;
    logic [31:0]         ioOff;
    dataBusPkg::busRegion region;
    dataBusPkg::laneMask  lanes;
    dataBusPkg::busData   shifted;

    // Unsigned offsets wrap below the base, so one compare covers each window.
    assign ramOff = 32'(req.addr) - 32'(dataBusPkg::ramBase);
    assign ioOff  = 32'(req.addr) - 32'(dataBusPkg::ioBase);

    always_comb begin
        if (ramOff < dataBusPkg::ramBytes) begin
            region = dataBusPkg::regionRam;
        end else if (ioOff < dataBusPkg::ioWords * 4) begin
            region = dataBusPkg::regionIo;
        end else begin
            region = dataBusPkg::regionNone;
        end
    end

    always_comb begin
        shifted = req.wrData;
        lanes   = 4'b0000;
        unique casez ({req.access, req.addr[1:0]})
            {dataBusPkg::accessByte, 2'b00}: begin
                shifted = {24'b0, req.wrData[7:0]};
                lanes   = 4'b0001;
            end
            {dataBusPkg::accessByte, 2'b01}: begin
                shifted = {16'b0, req.wrData[7:0], 8'b0};
                lanes   = 4'b0010;
            end
            {dataBusPkg::accessByte, 2'b10}: begin
                shifted = {8'b0, req.wrData[7:0], 16'b0};
                lanes   = 4'b0100;
            end
            {dataBusPkg::accessByte, 2'b11}: begin
                shifted = {req.wrData[7:0], 24'b0};
                lanes   = 4'b1000;
            end
            {dataBusPkg::accessHalf, 2'b0?}: begin
                shifted = {16'b0, req.wrData[15:0]};
                lanes   = 4'b0011;
            end
            {dataBusPkg::accessHalf, 2'b1?}: begin
                shifted = {req.wrData[15:0], 16'b0};
                lanes   = 4'b1100;
            end
            {dataBusPkg::accessWord, 2'b??}: begin
                shifted = req.wrData;
                lanes   = 4'b1111;
            end
            default: begin
                shifted = '0;      // Undefined size writes nothing.
                lanes   = 4'b0000;
            end
        endcase
    end

    assign wr.region   = region;
    assign wr.lanes    = (req.wrEnable && region != dataBusPkg::regionNone) ? lanes : 4'b0000;
    assign wr.data     = shifted;
    assign wr.wordAddr = req.addr[11:2];
    assign wr.ioSel    = req.addr[5:2];   // Same address, narrower slice.

    assign ctx.region     = region;
    assign ctx.access     = req.access;
    assign ctx.signedLoad = req.signedLoad;
    assign ctx.byteOffset = req.addr[1:0];

endmodule

// ==== hdl/ram1024x8.sv ====
`timescale 1ns/1ps

module ram1024x8 (
    input                      i_clock,
    input  dataBusPkg::bankAddr address,
    input                      wren,
    input  logic [7:0]         data,
    output logic [7:0]         q
);

    logic [7:0] mem [2**$bits(dataBusPkg::bankAddr)];

    always_ff @(posedge i_clock) begin
        if (wren) begin
            mem[address] <= data;
        end
        q <= mem[address];   // Old contents come out on a write.
    end

endmodule

// ==== hdl/dataMemory1024x32.sv ====
`timescale 1ns/1ps

module dataMemory1024x32 (
    input                          i_clock,
    input  dataBusPkg::alignedWrite wr,
    output dataBusPkg::busData      ramWord
);

    logic ramSel;

    assign ramSel = (wr.region == dataBusPkg::regionRam);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte banks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar lane = 0; lane < 4; lane++) begin : gBank
        ram1024x8 bank (
            .i_clock (i_clock),
            .address (wr.wordAddr),
            .wren    (wr.lanes[lane] & ramSel),
            .data    (wr.data[8*lane +: 8]),
            .q       (ramWord[8*lane +: 8])
        );
    end

endmodule

// ==== hdl/ioRegisterFile.sv ====
`timescale 1ns/1ps

module ioRegisterFile (
    input                          i_clock,
    input                          rstN,
    input  dataBusPkg::alignedWrite wr,
    output dataBusPkg::busData      ioWord
);

    dataBusPkg::busData regs [dataBusPkg::ioWords];
    logic               ioSel;

    assign ioSel = (wr.region == dataBusPkg::regionIo);

    always_ff @(posedge i_clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < dataBusPkg::ioWords; i++) begin
                regs[i] <= '0;
            end
        end else if (ioSel) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wr.lanes[lane]) begin
                    regs[wr.ioSel][8*lane +: 8] <= wr.data[8*lane +: 8];
                end
            end
        end
    end

    // Reads the value held before this edge, matching the RAM banks.
    always_ff @(posedge i_clock) begin
        ioWord <= regs[wr.ioSel];
    end

endmodule

// ==== hdl/loadUnit.sv ====
`timescale 1ns/1ps

module loadUnit (
    input                         i_clock,
    input                         rstN,
    input  dataBusPkg::loadContext ctx,
    input                         rdEnable,
    input  dataBusPkg::busData     ramWord,
    input  dataBusPkg::busData     ioWord,
    output dataBusPkg::busData     rdData,
    output logic                  rdValid
);

    dataBusPkg::loadContext ctxQ;
    dataBusPkg::busData     word;
    dataBusPkg::busData     shifted;
    logic [15:0]            half;

    // Captured on the same edge as the region read registers.
    always_ff @(posedge i_clock or negedge rstN) begin
        if (!rstN) begin
            ctxQ.region     <= dataBusPkg::regionNone;
            ctxQ.access     <= dataBusPkg::accessWord;
            ctxQ.signedLoad <= 1'b0;
            ctxQ.byteOffset <= 2'b00;
            rdValid         <= 1'b0;
        end else begin
            ctxQ    <= ctx;
            rdValid <= rdEnable;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Return path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        unique case (ctxQ.region)
            dataBusPkg::regionRam: word = ramWord;
            dataBusPkg::regionIo:  word = ioWord;
            default:               word = '0;  // Unmapped reads give zero.
        endcase
    end

    assign shifted = word >> {ctxQ.byteOffset, 3'b000};
    assign half    = ctxQ.byteOffset[1] ? word[31:16] : word[15:0];  // Bit 0 is ignored.

    always_comb begin
        unique case (ctxQ.access)
            dataBusPkg::accessByte: begin
                rdData = {{24{ctxQ.signedLoad & shifted[7]}}, shifted[7:0]};
            end
            dataBusPkg::accessHalf: begin
                rdData = {{16{ctxQ.signedLoad & half[15]}}, half};
            end
            default: begin
                rdData = word;
            end
        endcase
    end

endmodule

// ==== hdl/dataBusSystem.sv ====
`timescale 1ns/1ps

module dataBusSystem (
    input                        i_clock,
    input                        rstN,
    input  dataBusPkg::busRequest req,
    output dataBusPkg::busData    rdData,
    output logic                 rdValid
);

    dataBusPkg::alignedWrite wr;
    dataBusPkg::loadContext  ctx;
    dataBusPkg::busData      ramWord;
    dataBusPkg::busData      ioWord;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    accessDecoder decoder (
        .req (req),
        .wr  (wr),
        .ctx (ctx)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Regions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    dataMemory1024x32 ram (
        .i_clock (i_clock),
        .wr      (wr),
        .ramWord (ramWord)
    );

    ioRegisterFile io (
        .i_clock (i_clock),
        .rstN    (rstN),
        .wr      (wr),
        .ioWord  (ioWord)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    loadUnit load (
        .i_clock  (i_clock),
        .rstN     (rstN),
        .ctx      (ctx),
        .rdEnable (req.rdEnable),
        .ramWord  (ramWord),
        .ioWord   (ioWord),
        .rdData   (rdData),
        .rdValid  (rdValid)
    );

endmodule

// ==== tb/dataBusSystem_assertions.sv ====
`timescale 1ns/1ps

module dataBusSystem_assertions (
    input                        i_clock,
    input                        rstN,
    input  dataBusPkg::busRequest req,
    input                        rdValid
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    strobesExclusive: assert property (
        @(posedge i_clock) disable iff (!rstN)
        !(req.wrEnable && req.rdEnable)
    ) else $error("wrEnable and rdEnable were high in the same cycle.");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read return timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    readReturns: assert property (
        @(posedge i_clock) disable iff (!rstN)
        req.rdEnable |=> rdValid
    ) else $error("rdValid did not follow a read strobe by one cycle.");

    noSpuriousValid: assert property (
        @(posedge i_clock) disable iff (!rstN)
        !req.rdEnable |=> !rdValid
    ) else $error("rdValid rose without a read strobe one cycle earlier.");

    quietInReset: assert property (
        @(posedge i_clock)
        !rstN |-> !rdValid
    ) else $error("rdValid was high during reset.");

endmodule

bind dataBusSystem dataBusSystem_assertions protocolChecks (
    .i_clock (i_clock),
    .rstN    (rstN),
    .req     (req),
    .rdValid (rdValid)
);

// ==== tb/dataBusSystemTb.sv ====
`timescale 1ns/1ps

module dataBusSystemTb;

    localparam int randomItems = 3000;
    localparam int drainLimit  = 20;
    localparam int readbackMax = 40;

    logic                  i_clock;
    logic                  rstN;
    dataBusPkg::busRequest req;
    dataBusPkg::busData    rdData;
    logic                  rdValid;

    logic [7:0]  ramModel [4096];
    logic        ramKnown [4096];   // Set once a byte has been written.
    logic [7:0]  ioModel  [64];
    logic [31:0] rngState;
    logic [31:0] expData  [$];
    logic [15:0] expAddr  [$];

    dataBusSystem dataBusSystem_inst (
        .i_clock (i_clock),
        .rstN    (rstN),
        .req     (req),
        .rdData  (rdData),
        .rdValid (rdValid)
    );

    always #50 i_clock = ~i_clock;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reporting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            failRun($sformatf("CHECK FAILED at time %0t: %s, got %h, expected %h",
                              $time, what, actual, expected));
        end
    endtask

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // 0 is RAM, 1 is the I/O window, 2 is unmapped.
    function automatic int regionOf(input logic [15:0] addr);
        if (addr < 16'h1000) begin
            return 0;
        end
        if (addr < 16'h1040) begin
            return 1;   // Sixteen registers of four bytes.
        end
        return 2;
    endfunction

    function automatic logic [15:0] firstByte(input logic [15:0] addr,
                                              input dataBusPkg::dataAccess access);
        case (access)
            dataBusPkg::accessByte: return addr;
            dataBusPkg::accessHalf: return {addr[15:2], addr[1], 1'b0};
            default:                return {addr[15:2], 2'b00};
        endcase
    endfunction

    function automatic int byteCount(input dataBusPkg::dataAccess access);
        case (access)
            dataBusPkg::accessByte: return 1;
            dataBusPkg::accessHalf: return 2;
            default:                return 4;
        endcase
    endfunction

    function automatic logic [7:0] modelByte(input logic [15:0] addr);
        case (regionOf(addr))
            0:       return ramModel[addr[11:0]];
            1:       return ioModel[addr[5:0]];
            default: return 8'h00;
        endcase
    endfunction

    function automatic void storeByte(input logic [15:0] addr, input logic [7:0] value);
        if (regionOf(addr) == 0) begin
            ramModel[addr[11:0]] = value;
            ramKnown[addr[11:0]] = 1'b1;
        end else if (regionOf(addr) == 1) begin
            ioModel[addr[5:0]] = value;
        end
    endfunction

    function automatic logic loadKnown(input logic [15:0] addr,
                                       input dataBusPkg::dataAccess access);
        logic [15:0] first;
        logic [15:0] at;
        logic        known;
        first = firstByte(addr, access);
        known = 1'b1;
        for (int i = 0; i < byteCount(access); i++) begin
            at = first + 16'(i);
            if (regionOf(at) == 0 && !ramKnown[at[11:0]]) begin
                known = 1'b0;
            end
        end
        return known;
    endfunction

    function automatic logic [31:0] expectedLoad(input logic [15:0] addr,
                                                 input dataBusPkg::dataAccess access,
                                                 input logic signedLoad);
        logic [15:0] first;
        logic [31:0] value;
        first = firstByte(addr, access);
        value = '0;
        for (int i = 0; i < byteCount(access); i++) begin
            value[8*i +: 8] = modelByte(first + 16'(i));
        end
        if (signedLoad && access == dataBusPkg::accessByte) begin
            value = {{24{value[7]}}, value[7:0]};
        end else if (signedLoad && access == dataBusPkg::accessHalf) begin
            value = {{16{value[15]}}, value[15:0]};
        end
        return value;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Driving and checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Drives one request for one cycle and updates the model.
    task automatic issue(input logic [15:0] addr, input dataBusPkg::dataAccess access,
                         input logic signedLoad, input logic isWrite, input logic [31:0] data);
        logic [15:0] first;
        first          = firstByte(addr, access);
        req.addr       = addr;
        req.access     = access;
        req.signedLoad = signedLoad;
        req.wrEnable   = isWrite;
        req.rdEnable   = !isWrite;
        req.wrData     = data;
        if (isWrite) begin
            for (int i = 0; i < byteCount(access); i++) begin
                storeByte(first + 16'(i), data[8*i +: 8]);   // Lane i of the access.
            end
        end else begin
            expData.push_back(expectedLoad(addr, access, signedLoad));
            expAddr.push_back(addr);
        end
        @(posedge i_clock);
        #1;
    endtask

    function automatic logic [15:0] unmappedAddress();
        return 16'h1040 + 16'(nextRandom() % 32'h0000efc0);
    endfunction

    always begin
        logic [31:0] want;
        logic [15:0] from;
        @(posedge i_clock);
        #2;
        if (rstN && rdValid) begin
            if (expData.size() == 0) begin
                failRun("rdValid was high with no read outstanding.");
            end else begin
                want = expData.pop_front();
                from = expAddr.pop_front();
                checkValue(rdData, want, $sformatf("load from address %h", from));
            end
        end
    end

    initial begin
        logic [31:0]           r;
        logic [15:0]           addr;
        logic [31:0]           data;
        logic                  isWrite;
        dataBusPkg::dataAccess access;
        int                    count;
        int                    waited;
        i_clock  = 1'b0;
        rstN     = 1'b0;
        req      = '0;
        rngState = 32'hef6b;
        for (int i = 0; i < 4096; i++) begin
            ramModel[i] = 8'h00;
            ramKnown[i] = 1'b0;
        end
        for (int i = 0; i < 64; i++) begin
            ioModel[i] = 8'h00;
        end
        repeat (3) @(posedge i_clock);
        #1;
        rstN = 1'b1;
        @(posedge i_clock);
        #1;

        // Every I/O register starts at zero.
        for (int i = 0; i < 16; i++) begin
            issue(16'h1000 + 16'(4 * i), dataBusPkg::accessWord, 1'b0, 1'b0, 32'h0);
        end

        // Word round trip with both sign flags.
        repeat (8) begin
            addr = 16'(nextRandom() & 32'h00000ffc);
            issue(addr, dataBusPkg::accessWord, 1'b0, 1'b1, nextRandom());
            issue(addr, dataBusPkg::accessWord, 1'b0, 1'b0, 32'h0);
            issue(addr, dataBusPkg::accessWord, 1'b1, 1'b0, 32'h0);
        end

        // Partial stores, then every lane loaded with and without extension.
        repeat (8) begin
            r    = nextRandom();
            addr = {4'h0, r[11:2], 2'b00};
            issue(addr, dataBusPkg::accessWord, 1'b0, 1'b1, nextRandom());
            issue(addr | 16'(r[13:12]), dataBusPkg::accessByte, 1'b0, 1'b1, nextRandom());
            issue(addr | 16'(r[15:14]), dataBusPkg::accessHalf, 1'b0, 1'b1, nextRandom());
            for (int off = 0; off < 4; off++) begin
                issue(addr | 16'(off), dataBusPkg::accessByte, 1'b0, 1'b0, 32'h0);
                issue(addr | 16'(off), dataBusPkg::accessByte, 1'b1, 1'b0, 32'h0);
                issue(addr | 16'(off), dataBusPkg::accessHalf, 1'b0, 1'b0, 32'h0);
                issue(addr | 16'(off), dataBusPkg::accessHalf, 1'b1, 1'b0, 32'h0);
            end
            issue(addr, dataBusPkg::accessWord, 1'b0, 1'b0, 32'h0);
        end

        // RAM words that share their word index with the I/O registers.
        for (int i = 0; i < 16; i++) begin
            issue(16'(4 * i), dataBusPkg::accessWord, 1'b0, 1'b1, nextRandom());
        end

        // Byte lanes in the I/O window.
        for (int i = 0; i < 16; i++) begin
            r    = nextRandom();
            addr = 16'h1000 + 16'(4 * i);
            issue(addr | 16'(r[1:0]), dataBusPkg::accessByte, 1'b0, 1'b1, nextRandom());
            issue(addr | 16'(r[3:2]), dataBusPkg::accessHalf, 1'b0, 1'b1, nextRandom());
            issue(addr, dataBusPkg::accessWord, 1'b0, 1'b0, 32'h0);
            issue(addr | 16'(r[5:4]), dataBusPkg::accessByte, 1'b1, 1'b0, 32'h0);
        end

        // Unmapped traffic, then both regions read back.
        for (int i = 0; i < 16; i++) begin
            addr = 16'h2000 | 16'(4 * i);   // Same low bits as RAM and I/O word i.
            issue(addr, dataBusPkg::accessWord, 1'b0, 1'b1, nextRandom());
            issue(unmappedAddress(), dataBusPkg::accessByte, 1'b0, 1'b1, nextRandom());
            issue(unmappedAddress(), dataBusPkg::accessWord, 1'b0, 1'b0, 32'h0);
            issue(unmappedAddress(), dataBusPkg::accessByte, 1'b1, 1'b0, 32'h0);
        end
        for (int i = 0; i < 16; i++) begin
            issue(16'h1000 + 16'(4 * i), dataBusPkg::accessWord, 1'b0, 1'b0, 32'h0);
        end
        count = 0;
        for (int w = 0; w < 1024; w++) begin
            addr = 16'(4 * w);
            if (count < readbackMax && loadKnown(addr, dataBusPkg::accessWord)) begin
                issue(addr, dataBusPkg::accessWord, 1'b0, 1'b0, 32'h0);
                count++;
            end
        end

        // Back-to-back random stream with no idle cycles.
        for (int n = 0; n < randomItems; n++) begin
            r = nextRandom();
            case (r[1:0])
                2'd0, 2'd1: addr = {7'b0, r[24:16]};        // 512-byte RAM window.
                2'd2:       addr = 16'h1000 | 16'(r[21:16]);
                default:    addr = unmappedAddress();
            endcase
            access  = (r[3:2] == 2'd3) ? dataBusPkg::accessWord
                                       : dataBusPkg::dataAccess'(r[3:2]);
            isWrite = r[4] || !loadKnown(addr, access);
            data    = nextRandom();
            issue(addr, access, r[5], isWrite, data);
        end

        req.wrEnable = 1'b0;
        req.rdEnable = 1'b0;
        waited = 0;
        while (expData.size() != 0 && waited < drainLimit) begin
            @(posedge i_clock);
            #3;
            waited++;
        end
        if (expData.size() != 0) begin
            failRun("Timeout while waiting for outstanding reads to return.");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== dataBusSystem.f ====
hdl/dataBusPkg.sv
hdl/accessDecoder.sv
hdl/ram1024x8.sv
hdl/dataMemory1024x32.sv
hdl/ioRegisterFile.sv
hdl/loadUnit.sv
hdl/dataBusSystem.sv
tb/dataBusSystem_assertions.sv
tb/dataBusSystemTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module dataBusSystemTb \
    -f dataBusSystem.f

./obj_dir/VdataBusSystemTb | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation reported a failure."
    exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
    echo "Simulation ended without a result line."
    exit 1
fi
